//--- design/code_store.sv
module code_store (
  input  logic                      clk,
  input  logic                      rst,
  input  smt_fetch_pkg::fill_t      fill,
  input  logic                      rd_en,
  input  smt_fetch_pkg::thread_t    rd_thread,
  input  smt_fetch_pkg::ip_t        rd_addr,
  output smt_fetch_pkg::fetch_rsp_t rsp
);

  import smt_fetch_pkg::*;

  word_t mem [DEPTH];

  // fill port from the outside bus
  always_ff @(posedge clk) begin
    if (fill.en) begin
      mem[fill.addr] <= fill.data;
    end
  end

  // registered read, a same-cycle fill gives the old word
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp.valid <= 1'b0;
    end else begin
      rsp.valid <= rd_en;
    end
    if (rd_en) begin
      rsp.thread <= rd_thread;
      rsp.ip <= rd_addr;
      rsp.word <= mem[rd_addr];
    end
  end

endmodule : code_store

//--- design/fetch_unit.sv
module fetch_unit #(
  parameter smt_fetch_pkg::thread_t THREAD_ID = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      redirect,
  input  smt_fetch_pkg::ip_t        redirect_ip,
  input  logic                      grant,
  input  smt_fetch_pkg::fetch_rsp_t rsp,
  output logic                      req,
  output smt_fetch_pkg::ip_t        req_ip,
  output logic                      running
);

  import smt_fetch_pkg::*;

  ip_t  ip;
  logic pending;
  logic rsp_hit;
  logic rsp_halt;

  // only a response we are waiting for counts
  // a word fetched before a redirect goes to the decoder but is ignored here
  assign rsp_hit = rsp.valid && (rsp.thread == THREAD_ID) && pending;
  assign rsp_halt = rsp_hit && (opcode_e'(rsp.word[OPC_HI:OPC_LO]) == OP_HALT);

  // one word in flight per thread
  assign req = running && !pending;
  assign req_ip = ip;

  always_ff @(posedge clk) begin
    if (rst) begin
      ip <= '0;
      running <= 1'b0;
      pending <= 1'b0;
    end else if (redirect) begin
      ip <= redirect_ip;
      running <= 1'b1;
      pending <= 1'b0;
    end else begin
      if (grant) begin
        // wraps at the top of the store
        ip <= ip + ip_t'(1);
        pending <= 1'b1;
      end else if (rsp_hit) begin
        pending <= 1'b0;
      end
      if (rsp_halt) begin
        running <= 1'b0;
      end
    end
  end

endmodule : fetch_unit

//--- design/insn_decoder.sv
module insn_decoder (
  input  logic                      clk,
  input  logic                      rst,
  input  smt_fetch_pkg::fetch_rsp_t rsp,
  output smt_fetch_pkg::decoded_t   dec
);

  import smt_fetch_pkg::*;

  opcode_e   opc;
  op_class_e op_class;
  reg_idx_t  rd;
  reg_idx_t  ra;
  imm_t      imm;
  data_t     imm_ext;
  logic      writes_rd;

  assign opc = opcode_e'(rsp.word[OPC_HI:OPC_LO]);
  assign rd = rsp.word[RD_LSB +: $bits(reg_idx_t)];
  assign ra = rsp.word[RA_LSB +: $bits(reg_idx_t)];
  assign imm = rsp.word[$bits(imm_t)-1:0];
  assign imm_ext = {{($bits(data_t) - $bits(imm_t)){imm[$bits(imm_t)-1]}}, imm};

  always_comb begin
    case (opc)
      OP_HALT:   op_class = CL_HALT;
      OP_ALU:    op_class = CL_ALU;
      OP_ALUI:   op_class = CL_ALUI;
      OP_LOAD:   op_class = CL_LOAD;
      OP_STORE:  op_class = CL_STORE;
      OP_BRANCH: op_class = CL_BRANCH;
      default:   op_class = CL_ILLEGAL;
    endcase
  end

  // r0 is never a real destination
  assign writes_rd = (op_class inside {CL_ALU, CL_ALUI, CL_LOAD}) && (rd != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= rsp.valid;
    end
    if (rsp.valid) begin
      dec.thread <= rsp.thread;
      dec.ip <= rsp.ip;
      dec.op_class <= op_class;
      dec.rd <= rd;
      dec.ra <= ra;
      dec.imm <= imm_ext;
      dec.writes_rd <= writes_rd;
    end
  end

endmodule : insn_decoder

//--- design/smt_fetch.sv
module smt_fetch (
  input  logic                                  clk,
  input  logic                                  rst,
  input  smt_fetch_pkg::fill_t                  fill,
  input  logic                                  except,
  input  smt_fetch_pkg::thread_t                except_thread,
  input  smt_fetch_pkg::ip_t                    except_ip,
  input  logic                                  stall,
  output smt_fetch_pkg::decoded_t               dec,
  output logic [smt_fetch_pkg::NUM_THREADS-1:0] running
);

  import smt_fetch_pkg::*;

  logic [NUM_THREADS-1:0] req;
  logic [NUM_THREADS-1:0] redirect;
  logic [NUM_THREADS-1:0] grant;
  ip_t                    req_ip [NUM_THREADS];
  logic                   grant_en;
  thread_t                grant_thread;
  ip_t                    rd_addr;
  fetch_rsp_t             rsp;

  // per-thread redirect and grant strobes
  always_comb begin
    for (int t = 0; t < NUM_THREADS; t++) begin
      redirect[t] = except && (except_thread == thread_t'(t));
      grant[t] = grant_en && (grant_thread == thread_t'(t));
    end
  end

  // store address from the granted thread
  assign rd_addr = req_ip[grant_thread];

  fetch_unit #(
    .THREAD_ID(thread_t'(0))
  ) fetch0 (
    .clk(clk),
    .rst(rst),
    .redirect(redirect[0]),
    .redirect_ip(except_ip),
    .grant(grant[0]),
    .rsp(rsp),
    .req(req[0]),
    .req_ip(req_ip[0]),
    .running(running[0])
  );

  fetch_unit #(
    .THREAD_ID(thread_t'(1))
  ) fetch1 (
    .clk(clk),
    .rst(rst),
    .redirect(redirect[1]),
    .redirect_ip(except_ip),
    .grant(grant[1]),
    .rsp(rsp),
    .req(req[1]),
    .req_ip(req_ip[1]),
    .running(running[1])
  );

  thread_select sel0 (
    .clk(clk),
    .rst(rst),
    .req(req),
    .stall(stall),
    .grant_en(grant_en),
    .grant_thread(grant_thread)
  );

  code_store store0 (
    .clk(clk),
    .rst(rst),
    .fill(fill),
    .rd_en(grant_en),
    .rd_thread(grant_thread),
    .rd_addr(rd_addr),
    .rsp(rsp)
  );

  insn_decoder dec0 (
    .clk(clk),
    .rst(rst),
    .rsp(rsp),
    .dec(dec)
  );

endmodule : smt_fetch

//--- design/smt_fetch_pkg.sv
package smt_fetch_pkg;

  // code store geometry
  localparam int ADDR_W = 6;
  localparam int DEPTH = 1 << ADDR_W;
  localparam int WORD_W = 32;

  localparam int NUM_THREADS = 2;

  // instruction field positions
  localparam int OPC_HI = 31;
  localparam int OPC_LO = 26;
  localparam int RD_LSB = 21;
  localparam int RA_LSB = 16;

  typedef logic [ADDR_W-1:0] ip_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [15:0] imm_t;
  typedef logic [31:0] data_t;
  typedef logic [0:0] thread_t;

  typedef enum logic [5:0] {
    OP_HALT   = 6'd0,
    OP_ALU    = 6'd1,
    OP_ALUI   = 6'd2,
    OP_LOAD   = 6'd3,
    OP_STORE  = 6'd4,
    OP_BRANCH = 6'd5
  } opcode_e;

  typedef enum logic [2:0] {
    CL_HALT,
    CL_ALU,
    CL_ALUI,
    CL_LOAD,
    CL_STORE,
    CL_BRANCH,
    CL_ILLEGAL
  } op_class_e;

  // bus write into the code store
  typedef struct packed {
    logic  en;
    ip_t   addr;
    word_t data;
  } fill_t;

  // word returned by the store, tagged with its thread
  typedef struct packed {
    logic    valid;
    thread_t thread;
    ip_t     ip;
    word_t   word;
  } fetch_rsp_t;

  typedef struct packed {
    logic      valid;
    thread_t   thread;
    ip_t       ip;
    op_class_e op_class;
    reg_idx_t  rd;
    reg_idx_t  ra;
    data_t     imm;
    logic      writes_rd;
  } decoded_t;

endpackage : smt_fetch_pkg

//--- design/thread_select.sv
module thread_select (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [smt_fetch_pkg::NUM_THREADS-1:0] req,
  input  logic                                  stall,
  output logic                                  grant_en,
  output smt_fetch_pkg::thread_t                grant_thread
);

  import smt_fetch_pkg::*;

  thread_t last;

  always_comb begin
    grant_en = !stall && (req != '0);
    case (req)
      2'b01: grant_thread = thread_t'(0);
      2'b10: grant_thread = thread_t'(1);
      // both want the port, alternate
      default: grant_thread = ~last;
    endcase
  end

  // starts at thread 1 so thread 0 takes the first tie
  always_ff @(posedge clk) begin
    if (rst) begin
      last <= thread_t'(1);
    end else if (grant_en) begin
      last <= grant_thread;
    end
  end

endmodule : thread_select

//--- smt_fetch.f
design/smt_fetch_pkg.sv
design/code_store.sv
design/fetch_unit.sv
design/thread_select.sv
design/insn_decoder.sv
design/smt_fetch.sv
testbench/smt_fetch_sva.sv
testbench/smt_fetch_tb.sv

//--- testbench/smt_fetch_sva.sv
module smt_fetch_sva (
  input logic                                  clk,
  input logic                                  rst,
  input logic                                  stall,
  input logic                                  grant_en,
  input smt_fetch_pkg::thread_t                grant_thread,
  input logic [smt_fetch_pkg::NUM_THREADS-1:0] req,
  input logic [smt_fetch_pkg::NUM_THREADS-1:0] pending,
  input logic                                  dec_valid
);

  import smt_fetch_pkg::*;

  thread_t last_grant;

  // thread that won the port most recently
  always_ff @(posedge clk) begin
    if (rst) begin
      last_grant <= thread_t'(1);
    end else if (grant_en) begin
      last_grant <= grant_thread;
    end
  end

  a_dec_idle_in_reset: assert property (@(posedge clk)
    rst |=> !dec_valid ##1 !dec_valid)
    else $error("dec.valid high during reset or in the cycle after it");

  a_no_grant_on_stall: assert property (@(posedge clk) disable iff (rst)
    stall |-> !grant_en ##2 !dec_valid)
    else $error("read port granted while stall is high or a word came out of it");

  a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
    grant_en |-> !pending[grant_thread])
    else $error("read port granted to a thread with a word still outstanding");

  a_alternate_on_tie: assert property (@(posedge clk) disable iff (rst)
    (grant_en && req == '1) |-> grant_thread != last_grant)
    else $error("same thread granted twice in a row while both request");

endmodule : smt_fetch_sva

bind smt_fetch smt_fetch_sva sva0 (
  .clk(clk),
  .rst(rst),
  .stall(stall),
  .grant_en(grant_en),
  .grant_thread(grant_thread),
  .req(req),
  .pending({fetch1.pending, fetch0.pending}),
  .dec_valid(dec.valid)
);

//--- testbench/smt_fetch_tb.sv
module smt_fetch_tb;

  import smt_fetch_pkg::*;

  // cycle budget of each test
  localparam int RESET_CYC = 12;
  localparam int SINGLE_CYC = 40;
  localparam int DUAL_CYC = 70;
  localparam int DECODE_CYC = 70;
  localparam int STALL_CYC = 60;
  localparam int RESTART_CYC = 30;
  localparam int TOTAL_CYC = RESET_CYC + SINGLE_CYC + DUAL_CYC + DECODE_CYC +
                             STALL_CYC + RESTART_CYC;

  logic                   clk = 1'b0;
  logic                   rst;
  fill_t                  fill;
  logic                   except;
  thread_t                except_thread;
  ip_t                    except_ip;
  logic                   stall;
  decoded_t               dec;
  logic [NUM_THREADS-1:0] running;

  word_t    model [DEPTH];
  decoded_t exp0_q [$];
  decoded_t exp1_q [$];
  decoded_t got0_q [$];
  decoded_t got1_q [$];
  int       rec_count = 0;

  smt_fetch dut0 (
    .clk(clk),
    .rst(rst),
    .fill(fill),
    .except(except),
    .except_thread(except_thread),
    .except_ip(except_ip),
    .stall(stall),
    .dec(dec),
    .running(running)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (2 * TOTAL_CYC) @(posedge clk);
    abort_run("watchdog expired before all tests finished");
  end

  // decoded records sorted by thread
  always @(negedge clk) begin
    if (!rst && dec.valid === 1'b1) begin
      rec_count++;
      if (dec.thread == thread_t'(0)) begin
        got0_q.push_back(dec);
      end else begin
        got1_q.push_back(dec);
      end
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] exp_val,
                       input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      abort_run($sformatf("[ERROR] t=%0t %s expected %0h actual %0h",
                          $time, name, exp_val, act_val));
    end
  endtask

  // expected decode of one word
  function automatic decoded_t predict(input thread_t t, input ip_t ip, input word_t w);
    decoded_t   d;
    logic [5:0] opc;
    opc = w[31:26];
    d.valid = 1'b1;
    d.thread = t;
    d.ip = ip;
    case (opc)
      6'd0: d.op_class = CL_HALT;
      6'd1: d.op_class = CL_ALU;
      6'd2: d.op_class = CL_ALUI;
      6'd3: d.op_class = CL_LOAD;
      6'd4: d.op_class = CL_STORE;
      6'd5: d.op_class = CL_BRANCH;
      default: d.op_class = CL_ILLEGAL;
    endcase
    d.rd = w[25:21];
    d.ra = w[20:16];
    d.imm = {{16{w[15]}}, w[15:0]};
    d.writes_rd = (opc inside {6'd1, 6'd2, 6'd3}) && (w[25:21] != 5'd0);
    return d;
  endfunction

  function automatic logic [5:0] pick_opcode(input int i, input bit wild);
    if (!wild) begin
      return 6'(1 + (i % 5));
    end
    case (i % 9)
      0: return 6'd1;
      1: return 6'd2;
      2: return 6'd3;
      3: return 6'd4;
      4: return 6'd5;
      5: return 6'd6;
      6: return 6'd17;
      7: return 6'd42;
      default: return 6'd63;
    endcase
  endfunction

  // program of len words, halt in the last one
  task automatic load_program(input ip_t base, input int len, input bit wild);
    logic [5:0] opc;
    reg_idx_t   rd;
    imm_t       imm;
    word_t      w;
    for (int i = 0; i < len; i++) begin
      opc = (i == len - 1) ? 6'd0 : pick_opcode(i, wild);
      rd = (i % 4 == 1) ? 5'd0 : 5'($urandom);
      imm = 16'($urandom);
      if (i % 3 == 0) begin
        imm[15] = 1'b1;
      end
      w = {opc, rd, 5'($urandom), imm};
      model[ip_t'(base + i)] = w;
      @(posedge clk);
      fill <= '{en: 1'b1, addr: ip_t'(base + i), data: w};
    end
    @(posedge clk);
    fill <= '0;
  endtask

  // stream a thread walks from start up to its halt
  task automatic expect_thread(input thread_t t, input ip_t start);
    ip_t ip;
    ip = start;
    for (int n = 0; n < DEPTH; n++) begin
      if (t == thread_t'(0)) begin
        exp0_q.push_back(predict(t, ip, model[ip]));
      end else begin
        exp1_q.push_back(predict(t, ip, model[ip]));
      end
      if (model[ip][31:26] == 6'd0) begin
        break;
      end
      ip = ip + ip_t'(1);
    end
  endtask

  task automatic send_redirect(input thread_t t, input ip_t ip);
    @(posedge clk);
    except <= 1'b1;
    except_thread <= t;
    except_ip <= ip;
    expect_thread(t, ip);
  endtask

  task automatic end_redirect();
    @(posedge clk);
    except <= 1'b0;
  endtask

  task automatic wait_idle(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (running != '0 && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (running != '0) begin
      abort_run("threads did not halt within the cycle limit");
    end else begin
      // let the last words drain through the decoder
      repeat (4) @(negedge clk);
    end
  endtask

  task automatic check_record(input decoded_t e, input decoded_t g);
    check("dec.thread", e.thread, g.thread);
    check("dec.ip", e.ip, g.ip);
    check("dec.op_class", e.op_class, g.op_class);
    check("dec.rd", e.rd, g.rd);
    check("dec.ra", e.ra, g.ra);
    check("dec.imm", e.imm, g.imm);
    check("dec.writes_rd", e.writes_rd, g.writes_rd);
  endtask

  task automatic compare_streams();
    check("thread 0 record count", exp0_q.size(), got0_q.size());
    check("thread 1 record count", exp1_q.size(), got1_q.size());
    foreach (exp0_q[i]) begin
      check_record(exp0_q[i], got0_q[i]);
    end
    foreach (exp1_q[i]) begin
      check_record(exp1_q[i], got1_q[i]);
    end
    exp0_q.delete();
    exp1_q.delete();
    got0_q.delete();
    got1_q.delete();
  endtask

  task automatic test_reset();
    for (int i = 0; i < RESET_CYC; i++) begin
      @(posedge clk);
      if (i == 7) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      check("dec.valid", 0, dec.valid);
      check("running", 0, running);
    end
  endtask

  task automatic test_single_thread();
    load_program(ip_t'(0), 8, 1'b0);
    send_redirect(thread_t'(0), ip_t'(0));
    end_redirect();
    wait_idle(SINGLE_CYC);
    compare_streams();
  endtask

  task automatic test_two_threads();
    load_program(ip_t'(8), 12, 1'b0);
    load_program(ip_t'(20), 12, 1'b0);
    send_redirect(thread_t'(0), ip_t'(8));
    send_redirect(thread_t'(1), ip_t'(20));
    end_redirect();
    wait_idle(DUAL_CYC);
    compare_streams();
  endtask

  task automatic test_decode_fields();
    load_program(ip_t'(32), 16, 1'b1);
    send_redirect(thread_t'(1), ip_t'(32));
    end_redirect();
    wait_idle(DECODE_CYC);
    compare_streams();
  endtask

  task automatic test_stall();
    int base;
    send_redirect(thread_t'(0), ip_t'(32));
    send_redirect(thread_t'(1), ip_t'(8));
    end_redirect();
    repeat (6) @(posedge clk);
    check("running at stall", 1, running != '0);
    stall <= 1'b1;
    base = rec_count;
    repeat (10) @(posedge clk);
    // only words already in flight may come out
    check("records after stall", 1, (rec_count - base) <= 2);
    stall <= 1'b0;
    wait_idle(STALL_CYC);
    compare_streams();
  endtask

  task automatic test_restart();
    check("running before restart", 0, running);
    send_redirect(thread_t'(0), ip_t'(4));
    send_redirect(thread_t'(1), ip_t'(25));
    end_redirect();
    wait_idle(RESTART_CYC);
    compare_streams();
  endtask

  initial begin
    void'($urandom(17));
    rst = 1'b1;
    fill = '0;
    except = 1'b0;
    except_thread = '0;
    except_ip = '0;
    stall = 1'b0;
    test_reset();
    test_single_thread();
    test_two_threads();
    test_decode_fields();
    test_stall();
    test_restart();
    $display("test passed");
    $finish;
  end

endmodule : smt_fetch_tb
